// ==== draw_ship.f ====
src/ship_pkg.sv
src/ship_move_ctl.sv
src/hit_detect.sv
src/life_tracker.sv
src/missile_ctl.sv
src/sprite_overlay.sv
src/draw_ship.sv
dv/draw_ship_tb.sv

// ==== dv/draw_ship_tb.sv ====
`timescale 1ns/100ps

module draw_ship_tb
  import ship_pkg::*;
();

  localparam int CLK_PERIOD   = 20;
  localparam int FRAME_CYCLES = 40;
  localparam int RESET_CYCLES = 8;
  localparam int MOVE_FRAMES  = 60;
  localparam int FLOOR_FRAMES = 160;
  localparam int CEIL_FRAMES  = 200;
  localparam int MAX_FLIGHT   = 100;
  localparam int PIXEL_CYCLES = 2000;
  localparam int HIT_WAIT     = 8;
  // worst case frames of all tests, pixel test counted in frames
  localparam int TOTAL_FRAMES = MOVE_FRAMES + FLOOR_FRAMES + CEIL_FRAMES + MAX_FLIGHT +
                                (int'(LIVES_START) + 2) * (RESPAWN_FRAMES + 1) + 5 +
                                PIXEL_CYCLES / FRAME_CYCLES;
  localparam int WATCHDOG_CYCLES = TOTAL_FRAMES * FRAME_CYCLES + 4 * RESET_CYCLES + 1000;

  logic   pclk = 1'b0;
  logic   rst_n_i;
  logic   left_i;
  logic   right_i;
  logic   fire_i;
  coord_t en_x [5];
  coord_t en_y [5];
  coord_t hcount_i;
  coord_t vcount_i;
  logic   hsync_i;
  logic   vsync_i;
  logic   hblnk_i;
  logic   vblnk_i;
  rgb_t   rgb_i;

  coord_t hcount_o;
  coord_t vcount_o;
  logic   hsync_o;
  logic   vsync_o;
  logic   hblnk_o;
  logic   vblnk_o;
  rgb_t   rgb_o;
  coord_t missile_x_o;
  coord_t missile_y_o;
  logic   missile_on_o;
  logic   ship_down_o;
  lives_t lives_o;
  logic   game_over_o;

  // reference model state
  logic   ref_valid = 1'b0;
  logic   ref_vb_prev;
  logic   ref_tick;
  int     ref_ship_x;
  logic   ref_hit;
  int     ref_lives;
  logic   ref_dead;
  logic   ref_over;
  int     ref_frames_down;
  logic   ref_mon;
  int     ref_mx = 0;
  int     ref_my = 0;
  coord_t ref_hcount;
  coord_t ref_vcount;
  logic   ref_hsync;
  logic   ref_vsync;
  logic   ref_hblnk;
  logic   ref_vblnk;
  rgb_t   ref_rgb;

  int     err_cnt = 0;
  int     test_err_base = 0;
  int     ok_tests = 0;
  int     bad_tests = 0;
  string  cur_test;

  always #(CLK_PERIOD / 2) pclk = ~pclk;

  draw_ship dut_i (
    .pclk         (pclk),
    .rst_n_i      (rst_n_i),
    .left_i       (left_i),
    .right_i      (right_i),
    .fire_i       (fire_i),
    .en_x1_i      (en_x[0]),
    .en_y1_i      (en_y[0]),
    .en_x2_i      (en_x[1]),
    .en_y2_i      (en_y[1]),
    .en_x3_i      (en_x[2]),
    .en_y3_i      (en_y[2]),
    .en_x4_i      (en_x[3]),
    .en_y4_i      (en_y[3]),
    .en_x5_i      (en_x[4]),
    .en_y5_i      (en_y[4]),
    .hcount_i     (hcount_i),
    .vcount_i     (vcount_i),
    .hsync_i      (hsync_i),
    .vsync_i      (vsync_i),
    .hblnk_i      (hblnk_i),
    .vblnk_i      (vblnk_i),
    .rgb_i        (rgb_i),
    .hcount_o     (hcount_o),
    .vcount_o     (vcount_o),
    .hsync_o      (hsync_o),
    .vsync_o      (vsync_o),
    .hblnk_o      (hblnk_o),
    .vblnk_o      (vblnk_o),
    .rgb_o        (rgb_o),
    .missile_x_o  (missile_x_o),
    .missile_y_o  (missile_y_o),
    .missile_on_o (missile_on_o),
    .ship_down_o  (ship_down_o),
    .lives_o      (lives_o),
    .game_over_o  (game_over_o)
  );

  function automatic logic point_in(int px, int py, int bx, int by, int bw, int bh);
    return (px >= bx) && (px < bx + bw) && (py >= by) && (py < by + bh);
  endfunction

  function automatic int next_ship_x(int x, logic go_left, logic go_right);
    int target;
    target = x;
    if (go_left && !go_right) target = x - int'(SHIP_STEP);
    if (go_right && !go_left) target = x + int'(SHIP_STEP);
    if (target < 0) target = 0;
    if (target > int'(SHIP_X_MAX)) target = int'(SHIP_X_MAX);
    return target;
  endfunction

  function automatic logic ship_is_hit(int sx);
    for (int i = 0; i < 5; i++) begin
      if (point_in(en_x[i], en_y[i], sx, SHIP_Y, SHIP_W, SHIP_H)) return 1'b1;
    end
    return 1'b0;
  endfunction

  // expected color of one pixel, missile over ship over hearts over background
  function automatic rgb_t expected_pixel(int hc, int vc, logic blank, rgb_t bg, int sx,
                                          logic down, int mx, int my, logic mon, int lives);
    if (blank) return '0;
    if (mon && point_in(hc, vc, mx, my, MISSILE_W, MISSILE_H)) return MISSILE_RGB;
    if (!down && point_in(hc, vc, sx, SHIP_Y, SHIP_W, SHIP_H)) return SHIP_RGB;
    for (int n = 0; n < lives; n++) begin
      if (point_in(hc, vc, LIFE_X + n * LIFE_GAP, LIFE_Y, LIFE_SIZE, LIFE_SIZE)) begin
        return LIFE_RGB;
      end
    end
    return bg;
  endfunction

  always @(posedge pclk) begin
    ref_hcount <= hcount_i;
    ref_vcount <= vcount_i;
    if (!rst_n_i) begin
      ref_valid       <= 1'b1;
      ref_vb_prev     <= 1'b0;
      ref_tick        <= 1'b0;
      ref_ship_x      <= SHIP_X_RESET;
      ref_hit         <= 1'b0;
      ref_lives       <= LIVES_START;
      ref_dead        <= 1'b0;
      ref_over        <= 1'b0;
      ref_frames_down <= 0;
      ref_mon         <= 1'b0;
      {ref_hsync, ref_vsync, ref_hblnk, ref_vblnk} <= 4'b0;
      ref_rgb         <= '0;
    end else begin
      ref_vb_prev <= vblnk_i;
      ref_tick    <= vblnk_i && !ref_vb_prev;
      if (ref_tick && !ref_dead) ref_ship_x <= next_ship_x(ref_ship_x, left_i, right_i);
      ref_hit <= ship_is_hit(ref_ship_x);
      if (ref_hit && !ref_dead) begin
        ref_lives       <= ref_lives - 1;
        ref_dead        <= 1'b1;
        ref_frames_down <= 0;
        if (ref_lives == 1) ref_over <= 1'b1;
      end else if (ref_dead && !ref_over && ref_tick) begin
        if (ref_frames_down + 1 == RESPAWN_FRAMES) ref_dead <= 1'b0;
        ref_frames_down <= ref_frames_down + 1;
      end
      if (ref_dead) begin
        ref_mon <= 1'b0;
      end else if (fire_i && !ref_mon) begin
        ref_mon <= 1'b1;
        ref_mx  <= ref_ship_x + MISSILE_OFFSET;
        ref_my  <= SHIP_Y - MISSILE_H;
      end else if (ref_mon && ref_tick) begin
        if (ref_my < MISSILE_STEP) ref_mon <= 1'b0;
        else ref_my <= ref_my - MISSILE_STEP;
      end
      {ref_hsync, ref_vsync, ref_hblnk, ref_vblnk} <= {hsync_i, vsync_i, hblnk_i, vblnk_i};
      ref_rgb <= expected_pixel(hcount_i, vcount_i, hblnk_i || vblnk_i, rgb_i, ref_ship_x,
                                ref_dead, ref_mx, ref_my, ref_mon, ref_lives);
    end
  end

  task automatic check_value(string what, logic [31:0] got, logic [31:0] expected);
    assert (got === expected)
    else begin
      err_cnt++;
      $display("** Error at %0t: %s is %0h, expected %0h", $time, what, got, expected);
    end
  endtask

  task automatic note_failure(string msg);
    err_cnt++;
    $display("%s (time %0t)", msg, $time);
  endtask

  // outputs settle at the rising edge, compared half a cycle later
  always @(negedge pclk) begin
    if (ref_valid) begin
      check_value("hcount_o", hcount_o, ref_hcount);
      check_value("vcount_o", vcount_o, ref_vcount);
      check_value("hsync_o", hsync_o, ref_hsync);
      check_value("vsync_o", vsync_o, ref_vsync);
      check_value("hblnk_o", hblnk_o, ref_hblnk);
      check_value("vblnk_o", vblnk_o, ref_vblnk);
      check_value("rgb_o", rgb_o, ref_rgb);
      check_value("ship_down_o", ship_down_o, ref_hit);
      check_value("lives_o", lives_o, ref_lives);
      check_value("game_over_o", game_over_o, ref_over);
      check_value("missile_on_o", missile_on_o, ref_mon);
      if (ref_mon) begin
        check_value("missile_x_o", missile_x_o, ref_mx);
        check_value("missile_y_o", missile_y_o, ref_my);
      end
    end
  end

  task automatic step();
    @(posedge pclk);
    #2;
  endtask

  task automatic idle_inputs();
    {left_i, right_i, fire_i} = 3'b0;
    for (int i = 0; i < 5; i++) begin
      en_x[i] = '0;
      en_y[i] = '0;
    end
    hcount_i = '0;
    vcount_i = '0;
    {hsync_i, vsync_i, hblnk_i, vblnk_i} = 4'b0;
    rgb_i = '0;
  endtask

  task automatic do_reset();
    idle_inputs();
    rst_n_i = 1'b0;
    repeat (RESET_CYCLES) step();
    rst_n_i = 1'b1;
  endtask

  function automatic coord_t ship_probe_x(int k, int sx);
    case (k % 4)
      0: return coord_t'(sx - 1);
      1: return coord_t'(sx);
      2: return coord_t'(sx + SHIP_W - 1);
      default: return coord_t'(sx + SHIP_W);
    endcase
  endfunction

  // one short frame: vblank pulse, then probes on the ship edges
  task automatic run_frame(input logic go_left, input logic go_right, input logic shoot);
    left_i  = go_left;
    right_i = go_right;
    fire_i  = shoot;
    for (int k = 0; k < FRAME_CYCLES; k++) begin
      vblnk_i  = (k == 0);
      vsync_i  = (k == 0);
      hblnk_i  = 1'b0;
      hsync_i  = (k % 8 == 7);
      vcount_i = ((k / 4) % 2 == 0) ? SHIP_Y : coord_t'(SHIP_Y + SHIP_H - 1);
      hcount_i = ship_probe_x(k, ref_ship_x);
      rgb_i    = 12'h00F;
      step();
    end
  endtask

  task automatic hit_ship();
    int idx;
    int waited;
    idx = rand_range(0, 4);
    en_x[idx] = coord_t'(ref_ship_x + rand_range(0, SHIP_W - 1));
    en_y[idx] = coord_t'(SHIP_Y + rand_range(0, SHIP_H - 1));
    step();
    en_x[idx] = '0;
    en_y[idx] = '0;
    waited = 0;
    while (!ship_down_o && waited < HIT_WAIT) begin
      step();
      waited++;
    end
    if (!ship_down_o) begin
      note_failure("ship_down_o did not pulse for an enemy point inside the ship box");
    end
  endtask

  function automatic int rand_range(int lo, int hi);
    return lo + int'($urandom % (hi - lo + 1));
  endfunction

  // probes biased onto the missile, the ship and the hearts
  task automatic drive_random_pixel();
    int pick;
    int icon;
    pick = rand_range(0, 3);
    icon = rand_range(0, 2);
    case (pick)
      0: begin
        hcount_i = coord_t'(ref_mx + rand_range(-2, MISSILE_W + 1));
        vcount_i = coord_t'(ref_my + rand_range(-2, MISSILE_H + 1));
      end
      1: begin
        hcount_i = coord_t'(ref_ship_x + rand_range(-2, SHIP_W + 1));
        vcount_i = coord_t'(SHIP_Y + rand_range(-2, SHIP_H + 1));
      end
      2: begin
        hcount_i = coord_t'(LIFE_X + icon * LIFE_GAP + rand_range(-2, LIFE_SIZE + 1));
        vcount_i = coord_t'(LIFE_Y + rand_range(-2, LIFE_SIZE + 1));
      end
      default: begin
        hcount_i = coord_t'(rand_range(0, 1023));
        vcount_i = coord_t'(rand_range(0, 1023));
      end
    endcase
    hblnk_i = (rand_range(0, 5) == 0);
    vblnk_i = (rand_range(0, 31) == 0);
    hsync_i = rand_range(0, 1);
    vsync_i = rand_range(0, 1);
    rgb_i   = rgb_t'($urandom);
    fire_i  = (rand_range(0, 63) == 0);
  endtask

  task automatic start_test(string name);
    cur_test = name;
    test_err_base = err_cnt;
  endtask

  task automatic finish_test();
    if (err_cnt == test_err_base) begin
      ok_tests++;
      $display("%-16s ok", cur_test);
    end else begin
      bad_tests++;
      $display("%-16s FAILED with %0d errors", cur_test, err_cnt - test_err_base);
    end
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout: the run did not finish within the expected number of frames");
    $display("test failed");
    $finish;
  end

  initial begin
    int unsigned seed_val;
    int flight;
    int launch_y;
    int lives_before;
    logic [1:0] dir;
    seed_val = $urandom(99);
    rst_n_i = 1'b0;
    idle_inputs();

    start_test("reset");
    do_reset();
    check_value("lives after reset", lives_o, LIVES_START);
    check_value("missile_on after reset", missile_on_o, 0);
    check_value("game_over after reset", game_over_o, 0);
    check_value("rgb after reset", rgb_o, 0);
    hcount_i = SHIP_X_RESET;
    vcount_i = SHIP_Y;
    rgb_i = 12'h00F;
    step();
    check_value("ship pixel at reset x", rgb_o, SHIP_RGB);
    hcount_i = SHIP_X_RESET - 1;
    step();
    check_value("pixel left of ship", rgb_o, 12'h00F);
    finish_test();

    start_test("movement");
    for (int f = 0; f < MOVE_FRAMES; f++) begin
      dir = 2'(rand_range(0, 3));
      run_frame(dir[0], dir[1], 1'b0);
    end
    repeat (FLOOR_FRAMES) run_frame(1'b1, 1'b0, 1'b0);
    repeat (CEIL_FRAMES) run_frame(1'b0, 1'b1, 1'b0);
    finish_test();

    start_test("missile flight");
    idle_inputs();
    fire_i = 1'b1;
    step();
    launch_y = SHIP_Y - MISSILE_H;
    check_value("missile_x at launch", missile_x_o, ref_ship_x + MISSILE_OFFSET);
    check_value("missile_y at launch", missile_y_o, launch_y);
    flight = 0;
    // fire stays held for the first frames and must not relaunch
    while (missile_on_o && flight < MAX_FLIGHT) begin
      run_frame(1'b0, 1'b0, flight < 10);
      flight++;
      if (missile_on_o) begin
        check_value("missile_y in flight", missile_y_o, launch_y - flight * MISSILE_STEP);
      end
    end
    check_value("frames from launch to retire", flight, launch_y / MISSILE_STEP + 1);
    finish_test();

    start_test("hit and respawn");
    idle_inputs();
    fire_i = 1'b1;
    step();
    fire_i = 1'b0;
    lives_before = lives_o;
    hit_ship();
    step();
    step();
    check_value("lives after hit", lives_o, lives_before - 1);
    check_value("missile_on after hit", missile_on_o, 0);
    for (int f = 1; f < RESPAWN_FRAMES; f++) begin
      run_frame(1'b1, 1'b0, 1'b1);
      check_value("missile_on while down", missile_on_o, 0);
      if (f == 2) hit_ship();
    end
    check_value("lives after second hit while down", lives_o, lives_before - 1);
    run_frame(1'b1, 1'b0, 1'b1);
    check_value("missile_on after respawn", missile_on_o, 1);
    finish_test();

    start_test("game over");
    do_reset();
    for (int h = 0; h < int'(LIVES_START); h++) begin
      hit_ship();
      repeat (RESPAWN_FRAMES + 1) run_frame(1'b0, 1'b0, 1'b0);
    end
    check_value("lives at game over", lives_o, 0);
    check_value("game_over_o", game_over_o, 1);
    repeat (5) run_frame(1'b1, 1'b0, 1'b1);
    check_value("missile_on after game over", missile_on_o, 0);
    check_value("game_over_o held", game_over_o, 1);
    // ship box still where it went down, right edge pixel
    en_x[0] = coord_t'(ref_ship_x + SHIP_W - 1);
    en_y[0] = SHIP_Y;
    step();
    check_value("hit on frozen ship box", ship_down_o, 1);
    en_x[0] = '0;
    en_y[0] = '0;
    finish_test();

    start_test("pixel mixing");
    do_reset();
    fire_i = 1'b1;
    step();
    for (int i = 0; i < PIXEL_CYCLES; i++) begin
      drive_random_pixel();
      step();
    end
    idle_inputs();
    step();
    finish_test();

    $display("tests ok: %0d, tests failing: %0d, errors: %0d", ok_tests, bad_tests, err_cnt);
    if (bad_tests == 0 && err_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== src/draw_ship.sv ====
`timescale 1ns/100ps

module draw_ship
  import ship_pkg::*;
(
  input  logic   pclk,
  input  logic   rst_n_i,

  input  logic   left_i,
  input  logic   right_i,
  input  logic   fire_i,

  // enemy missile points
  input  coord_t en_x1_i,
  input  coord_t en_y1_i,
  input  coord_t en_x2_i,
  input  coord_t en_y2_i,
  input  coord_t en_x3_i,
  input  coord_t en_y3_i,
  input  coord_t en_x4_i,
  input  coord_t en_y4_i,
  input  coord_t en_x5_i,
  input  coord_t en_y5_i,

  input  coord_t hcount_i,
  input  coord_t vcount_i,
  input  logic   hsync_i,
  input  logic   vsync_i,
  input  logic   hblnk_i,
  input  logic   vblnk_i,
  input  rgb_t   rgb_i,

  output coord_t hcount_o,
  output coord_t vcount_o,
  output logic   hsync_o,
  output logic   vsync_o,
  output logic   hblnk_o,
  output logic   vblnk_o,
  output rgb_t   rgb_o,

  output coord_t missile_x_o,
  output coord_t missile_y_o,
  output logic   missile_on_o,
  output logic   ship_down_o,
  output lives_t lives_o,
  output logic   game_over_o
);

  logic   frame_tick;
  logic   dead;
  coord_t ship_x;

  ship_move_ctl u_ship_move_ctl (
    .pclk         (pclk),
    .rst_n_i      (rst_n_i),
    .vblnk_i      (vblnk_i),
    .left_i       (left_i),
    .right_i      (right_i),
    .dead_i       (dead),
    .frame_tick_o (frame_tick),
    .ship_x_o     (ship_x)
  );

  // hit pulse goes straight out as ship_down_o
  hit_detect u_hit_detect (
    .pclk     (pclk),
    .rst_n_i  (rst_n_i),
    .ship_x_i (ship_x),
    .en_x1_i  (en_x1_i),
    .en_y1_i  (en_y1_i),
    .en_x2_i  (en_x2_i),
    .en_y2_i  (en_y2_i),
    .en_x3_i  (en_x3_i),
    .en_y3_i  (en_y3_i),
    .en_x4_i  (en_x4_i),
    .en_y4_i  (en_y4_i),
    .en_x5_i  (en_x5_i),
    .en_y5_i  (en_y5_i),
    .hit_o    (ship_down_o)
  );

  life_tracker u_life_tracker (
    .pclk         (pclk),
    .rst_n_i      (rst_n_i),
    .hit_i        (ship_down_o),
    .frame_tick_i (frame_tick),
    .dead_o       (dead),
    .lives_o      (lives_o),
    .game_over_o  (game_over_o)
  );

  missile_ctl u_missile_ctl (
    .pclk         (pclk),
    .rst_n_i      (rst_n_i),
    .fire_i       (fire_i),
    .frame_tick_i (frame_tick),
    .ship_x_i     (ship_x),
    .dead_i       (dead),
    .missile_x_o  (missile_x_o),
    .missile_y_o  (missile_y_o),
    .missile_on_o (missile_on_o)
  );

  sprite_overlay u_sprite_overlay (
    .pclk         (pclk),
    .rst_n_i      (rst_n_i),
    .hcount_i     (hcount_i),
    .vcount_i     (vcount_i),
    .hsync_i      (hsync_i),
    .vsync_i      (vsync_i),
    .hblnk_i      (hblnk_i),
    .vblnk_i      (vblnk_i),
    .rgb_i        (rgb_i),
    .ship_x_i     (ship_x),
    .dead_i       (dead),
    .missile_x_i  (missile_x_o),
    .missile_y_i  (missile_y_o),
    .missile_on_i (missile_on_o),
    .lives_i      (lives_o),
    .hcount_o     (hcount_o),
    .vcount_o     (vcount_o),
    .hsync_o      (hsync_o),
    .vsync_o      (vsync_o),
    .hblnk_o      (hblnk_o),
    .vblnk_o      (vblnk_o),
    .rgb_o        (rgb_o)
  );

endmodule

// ==== src/sprite_overlay.sv ====
`timescale 1ns/100ps

module sprite_overlay
  import ship_pkg::*;
(
  input  logic   pclk,
  input  logic   rst_n_i,

  input  coord_t hcount_i,
  input  coord_t vcount_i,
  input  logic   hsync_i,
  input  logic   vsync_i,
  input  logic   hblnk_i,
  input  logic   vblnk_i,
  input  rgb_t   rgb_i,

  input  coord_t ship_x_i,
  input  logic   dead_i,
  input  coord_t missile_x_i,
  input  coord_t missile_y_i,
  input  logic   missile_on_i,
  input  lives_t lives_i,

  output coord_t hcount_o,
  output coord_t vcount_o,
  output logic   hsync_o,
  output logic   vsync_o,
  output logic   hblnk_o,
  output logic   vblnk_o,
  output rgb_t   rgb_o
);

  logic on_missile;
  logic on_ship;
  logic on_life;
  rgb_t rgb_nxt;

  assign on_missile = missile_on_i &&
                      in_box(hcount_i, vcount_i, missile_x_i, missile_y_i,
                             MISSILE_W, MISSILE_H);

  assign on_ship = !dead_i &&
                   in_box(hcount_i, vcount_i, ship_x_i, SHIP_Y, SHIP_W, SHIP_H);

  // one icon per remaining life, left to right
  always_comb begin
    on_life = 1'b0;
    for (int n = 0; n < LIVES_START; n++) begin
      if (n < lives_i &&
          in_box(hcount_i, vcount_i, coord_t'(LIFE_X + n * LIFE_GAP), LIFE_Y,
                 LIFE_SIZE, LIFE_SIZE)) begin
        on_life = 1'b1;
      end
    end
  end

  // missile over ship over hearts over background
  always_comb begin
    if (hblnk_i || vblnk_i) begin
      rgb_nxt = '0;
    end else if (on_missile) begin
      rgb_nxt = MISSILE_RGB;
    end else if (on_ship) begin
      rgb_nxt = SHIP_RGB;
    end else if (on_life) begin
      rgb_nxt = LIFE_RGB;
    end else begin
      rgb_nxt = rgb_i;
    end
  end

  always_ff @(posedge pclk) begin
    if (!rst_n_i) begin
      hsync_o <= 1'b0;
      vsync_o <= 1'b0;
      hblnk_o <= 1'b0;
      vblnk_o <= 1'b0;
      rgb_o   <= '0;
    end else begin
      hsync_o <= hsync_i;
      vsync_o <= vsync_i;
      hblnk_o <= hblnk_i;
      vblnk_o <= vblnk_i;
      rgb_o   <= rgb_nxt;
    end
  end

  // counters just follow one cycle behind
  always_ff @(posedge pclk) begin
    hcount_o <= hcount_i;
    vcount_o <= vcount_i;
  end

endmodule

// ==== src/missile_ctl.sv ====
`timescale 1ns/100ps

module missile_ctl
  import ship_pkg::*;
(
  input  logic   pclk,
  input  logic   rst_n_i,
  input  logic   fire_i,
  input  logic   frame_tick_i,
  input  coord_t ship_x_i,
  input  logic   dead_i,
  output coord_t missile_x_o,
  output coord_t missile_y_o,
  output logic   missile_on_o
);

  logic launch;
  logic climb;
  logic at_top;

  assign launch = fire_i & ~missile_on_o & ~dead_i;
  assign climb  = missile_on_o & frame_tick_i;
  // next step would cross the top row
  assign at_top = (missile_y_o < MISSILE_STEP);

  always_ff @(posedge pclk) begin
    if (!rst_n_i) begin
      missile_on_o <= 1'b0;
    end else if (dead_i) begin
      missile_on_o <= 1'b0;
    end else if (launch) begin
      missile_on_o <= 1'b1;
    end else if (climb && at_top) begin
      missile_on_o <= 1'b0;
    end
  end

  // position only matters while the missile is on
  always_ff @(posedge pclk) begin
    if (launch) begin
      missile_x_o <= ship_x_i + MISSILE_OFFSET;
      missile_y_o <= SHIP_Y - MISSILE_H;
    end else if (climb && !at_top) begin
      missile_y_o <= missile_y_o - MISSILE_STEP;
    end
  end

  a_missile_above_ship: assert property (
    @(posedge pclk) disable iff (!rst_n_i) missile_on_o |-> (missile_y_o < SHIP_Y)
  ) else $error("missile on but not above the ship row");

endmodule

// ==== src/life_tracker.sv ====
`timescale 1ns/100ps

module life_tracker
  import ship_pkg::*;
(
  input  logic   pclk,
  input  logic   rst_n_i,
  input  logic   hit_i,
  input  logic   frame_tick_i,
  output logic   dead_o,
  output lives_t lives_o,
  output logic   game_over_o
);

  typedef enum logic [1:0] {
    ST_ALIVE,
    ST_DOWN,
    ST_OVER
  } life_state_t;

  life_state_t state;
  logic [2:0]  down_cnt;

  always_ff @(posedge pclk) begin
    if (!rst_n_i) begin
      state    <= ST_ALIVE;
      lives_o  <= LIVES_START;
      down_cnt <= '0;
    end else begin
      case (state)
        ST_ALIVE: begin
          if (hit_i) begin
            lives_o  <= lives_o - 2'd1;
            down_cnt <= '0;
            // last life gone
            state    <= (lives_o == 2'd1) ? ST_OVER : ST_DOWN;
          end
        end
        ST_DOWN: begin
          // hits are ignored while down
          if (frame_tick_i) begin
            down_cnt <= down_cnt + 3'd1;
            if (down_cnt == 3'(RESPAWN_FRAMES - 1)) begin
              state <= ST_ALIVE;
            end
          end
        end
        ST_OVER: begin
          // held until reset
          state <= ST_OVER;
        end
        default: begin
          state <= ST_ALIVE;
        end
      endcase
    end
  end

  assign dead_o      = (state != ST_ALIVE);
  assign game_over_o = (state == ST_OVER);

  // lives only count down from the start value, no wrap
  a_lives_no_rise: assert property (
    @(posedge pclk) disable iff (!rst_n_i) lives_o <= $past(lives_o)
  ) else $error("lives_o went up");

  a_over_dead: assert property (
    @(posedge pclk) disable iff (!rst_n_i) game_over_o |-> (dead_o && lives_o == '0)
  ) else $error("game over with ship alive or lives left");

endmodule

// ==== src/hit_detect.sv ====
`timescale 1ns/100ps

module hit_detect
  import ship_pkg::*;
(
  input  logic   pclk,
  input  logic   rst_n_i,
  input  coord_t ship_x_i,
  input  coord_t en_x1_i,
  input  coord_t en_y1_i,
  input  coord_t en_x2_i,
  input  coord_t en_y2_i,
  input  coord_t en_x3_i,
  input  coord_t en_y3_i,
  input  coord_t en_x4_i,
  input  coord_t en_y4_i,
  input  coord_t en_x5_i,
  input  coord_t en_y5_i,
  output logic   hit_o
);

  coord_t en_x [N_ENEMY];
  coord_t en_y [N_ENEMY];
  logic   overlap;

  assign en_x = '{en_x1_i, en_x2_i, en_x3_i, en_x4_i, en_x5_i};
  assign en_y = '{en_y1_i, en_y2_i, en_y3_i, en_y4_i, en_y5_i};

  // any enemy missile point inside the ship box
  always_comb begin
    overlap = 1'b0;
    for (int i = 0; i < N_ENEMY; i++) begin
      if (in_box(en_x[i], en_y[i], ship_x_i, SHIP_Y, SHIP_W, SHIP_H)) begin
        overlap = 1'b1;
      end
    end
  end

  always_ff @(posedge pclk) begin
    if (!rst_n_i) begin
      hit_o <= 1'b0;
    end else begin
      hit_o <= overlap;
    end
  end

endmodule

// ==== src/ship_move_ctl.sv ====
`timescale 1ns/100ps

module ship_move_ctl
  import ship_pkg::*;
(
  input  logic   pclk,
  input  logic   rst_n_i,
  input  logic   vblnk_i,
  input  logic   left_i,
  input  logic   right_i,
  input  logic   dead_i,
  output logic   frame_tick_o,
  output coord_t ship_x_o
);

  logic   vblnk_prev;
  logic   move_left;
  logic   move_right;
  coord_t x_left;
  coord_t x_right;

  // one pulse per frame on the rising edge of vblank
  always_ff @(posedge pclk) begin
    if (!rst_n_i) begin
      vblnk_prev   <= 1'b0;
      frame_tick_o <= 1'b0;
    end else begin
      vblnk_prev   <= vblnk_i;
      frame_tick_o <= vblnk_i & ~vblnk_prev;
    end
  end

  assign move_left  = left_i & ~right_i;
  assign move_right = right_i & ~left_i;

  // clamped next positions
  assign x_left  = (ship_x_o < SHIP_STEP) ? '0 : ship_x_o - SHIP_STEP;
  assign x_right = (ship_x_o > SHIP_X_MAX - SHIP_STEP) ? SHIP_X_MAX : ship_x_o + SHIP_STEP;

  always_ff @(posedge pclk) begin
    if (!rst_n_i) begin
      ship_x_o <= SHIP_X_RESET;
    end else if (frame_tick_o && !dead_i) begin
      if (move_left) begin
        ship_x_o <= x_left;
      end else if (move_right) begin
        ship_x_o <= x_right;
      end
    end
  end

  a_ship_x_range: assert property (
    @(posedge pclk) disable iff (!rst_n_i) ship_x_o <= SHIP_X_MAX
  ) else $error("ship_x_o beyond right edge");

endmodule

// ==== src/ship_pkg.sv ====
package ship_pkg;

  // screen coordinate, color and life count widths
  typedef logic [10:0] coord_t;
  typedef logic [11:0] rgb_t;
  typedef logic [1:0]  lives_t;

  // screen geometry
  localparam coord_t SCREEN_W = 11'd800;
  localparam coord_t SCREEN_H = 11'd600;

  // ship sits on a fixed row near the bottom
  localparam coord_t SHIP_W       = 11'd40;
  localparam coord_t SHIP_H       = 11'd20;
  localparam coord_t SHIP_Y       = SCREEN_H - 11'd60;
  localparam coord_t SHIP_X_RESET = 11'd380;
  localparam coord_t SHIP_X_MAX   = SCREEN_W - SHIP_W;
  localparam coord_t SHIP_STEP    = 11'd4;

  // player missile
  localparam coord_t MISSILE_W      = 11'd4;
  localparam coord_t MISSILE_H      = 11'd12;
  localparam coord_t MISSILE_OFFSET = 11'd18;
  localparam coord_t MISSILE_STEP   = 11'd8;

  // lives and the icons in the top left corner
  localparam lives_t LIVES_START    = 2'd3;
  localparam int     RESPAWN_FRAMES = 4;
  localparam coord_t LIFE_X         = 11'd20;
  localparam coord_t LIFE_Y         = 11'd20;
  localparam coord_t LIFE_SIZE      = 11'd16;
  localparam coord_t LIFE_GAP       = 11'd30;

  localparam int N_ENEMY = 5;

  localparam rgb_t SHIP_RGB    = 12'h0F0;
  localparam rgb_t MISSILE_RGB = 12'hFF0;
  localparam rgb_t LIFE_RGB    = 12'hF00;

  // point inside a box, right and bottom edges excluded
  function automatic logic in_box(coord_t px, coord_t py, coord_t bx, coord_t by,
                                  coord_t bw, coord_t bh);
    return (px >= bx) && (px < bx + bw) && (py >= by) && (py < by + bh);
  endfunction

endpackage
